/* Makefile */
TOP = tb_aes_uart_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f sources.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* aes_link_pkg.sv */
// AES block, header byte, core control types and frame FSM states
package aes_link_pkg;

  // Bytes in one key, plaintext or result block
  localparam int BLOCK_BYTES = 16;
  localparam int BLOCK_BITS  = 8 * BLOCK_BYTES;

  // Byte i sits at bits 8i+7 down to 8i
  typedef logic [BLOCK_BITS-1:0] block_t;

  // Byte position in a block, one spare bit so a count can reach BLOCK_BYTES
  typedef logic [$clog2(BLOCK_BYTES):0] byte_idx_t;

  // First byte of every host frame
  typedef struct packed {
    logic [6:0] reserved;
    logic       core_reset;  // Pulse the core reset before this frame
  } header_t;

  // Control lines toward the AES core
  typedef struct packed {
    logic en;     // Sticky once the first block is loaded
    logic rst_n;  // Active-low core reset
    logic kdrdy;  // Key and data ready, one cycle
  } aes_ctrl_t;

  // Frame assembler FSM
  typedef enum logic [1:0] {
    HEADER,  // Waiting for the header byte
    KEY,     // Collecting 16 key bytes
    DATA     // Collecting 16 plaintext bytes
  } frame_state_e;

endpackage

/* aes_uart_bridge.sv */
// Top level chaining receiver, frame assembler, result serializer and transmitter
module aes_uart_bridge #(
  parameter int CLKS_PER_BIT = 10416  // Clock frequency over baud rate
) (
  input  logic                    CLK,
  input  logic                    NRST,
  input  logic                    rx_uart,
  input  aes_link_pkg::block_t    dout_aes,
  input  logic                    dvld_aes,
  output logic                    tx_uart,
  output aes_link_pkg::block_t    kin_aes,
  output aes_link_pkg::block_t    din_aes,
  output aes_link_pkg::aes_ctrl_t ctrl_aes
);

  uart_pkg::byte_t rx_byte;
  logic            rx_valid;
  uart_pkg::byte_t tx_byte;
  logic            tx_valid;
  logic            tx_ready;

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .CLK      (CLK),
    .NRST     (NRST),
    .rxd      (rx_uart),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  frame_assembler u_frame_assembler (
    .CLK      (CLK),
    .NRST     (NRST),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .kin      (kin_aes),
    .din      (din_aes),
    .ctrl     (ctrl_aes)
  );

  // Result path back from the core
  block_serializer u_block_serializer (
    .CLK      (CLK),
    .NRST     (NRST),
    .dout     (dout_aes),
    .dvld     (dvld_aes),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .CLK      (CLK),
    .NRST     (NRST),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .txd      (tx_uart)
  );

endmodule

/* block_serializer.sv */
// Result capture on the dvld rising edge and byte-by-byte hand-off to the transmitter
module block_serializer (
  input  logic                 CLK,
  input  logic                 NRST,
  input  aes_link_pkg::block_t dout,
  input  logic                 dvld,
  output uart_pkg::byte_t      tx_byte,
  output logic                 tx_valid,
  input  logic                 tx_ready
);

  localparam int BW = uart_pkg::BITS_PER_BYTE;
  localparam aes_link_pkg::byte_idx_t LAST_IDX =
    aes_link_pkg::byte_idx_t'(aes_link_pkg::BLOCK_BYTES - 1);

  logic                    dvld_q;
  logic                    dvld_rise;
  logic                    xfer;
  aes_link_pkg::block_t    result;
  aes_link_pkg::byte_idx_t byte_idx;  // Next byte to offer

  assign dvld_rise = dvld && !dvld_q;
  assign xfer      = tx_valid && tx_ready;
  assign tx_byte   = result[BW*byte_idx +: BW];

  // New result only when nothing is pending
  always_ff @(posedge CLK) begin
    if (dvld_rise && !tx_valid) result <= dout;
  end

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      dvld_q   <= 1'b0;
      tx_valid <= 1'b0;
      byte_idx <= '0;
    end else begin
      dvld_q <= dvld;
      if (!tx_valid) begin
        tx_valid <= dvld_rise;  // Offer byte 0
      end else if (xfer) begin
        byte_idx <= (byte_idx == LAST_IDX) ? '0 : byte_idx + 1'b1;
        if (byte_idx == LAST_IDX) tx_valid <= 1'b0;
      end
    end
  end

  // Transmitter busy, offer must hold
  a_hold_when_stalled: assert property (@(posedge CLK) disable iff (!NRST)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte));

endmodule

/* frame_assembler.sv */
// Header decode, key and plaintext block assembly and AES control generation
module frame_assembler (
  input  logic                    CLK,
  input  logic                    NRST,
  input  uart_pkg::byte_t         rx_byte,
  input  logic                    rx_valid,
  output aes_link_pkg::block_t    kin,
  output aes_link_pkg::block_t    din,
  output aes_link_pkg::aes_ctrl_t ctrl
);

  localparam int BW = uart_pkg::BITS_PER_BYTE;
  localparam aes_link_pkg::byte_idx_t LAST_IDX =
    aes_link_pkg::byte_idx_t'(aes_link_pkg::BLOCK_BYTES - 1);

  aes_link_pkg::frame_state_e state;
  aes_link_pkg::byte_idx_t    byte_idx;
  aes_link_pkg::block_t       key_buf;   // Filled while the frame arrives
  aes_link_pkg::block_t       data_buf;
  aes_link_pkg::header_t      hdr;
  logic                       last_idx;
  logic                       frame_done;  // 33rd byte accepted

  assign hdr        = aes_link_pkg::header_t'(rx_byte);
  assign last_idx   = (byte_idx == LAST_IDX);
  assign frame_done = rx_valid && (state == aes_link_pkg::DATA) && last_idx;

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      state    <= aes_link_pkg::HEADER;
      byte_idx <= '0;
    end else if (rx_valid) begin
      case (state)
        aes_link_pkg::HEADER: begin
          state    <= aes_link_pkg::KEY;
          byte_idx <= '0;
        end
        aes_link_pkg::KEY: begin
          byte_idx <= last_idx ? '0 : byte_idx + 1'b1;
          if (last_idx) state <= aes_link_pkg::DATA;
        end
        aes_link_pkg::DATA: begin
          byte_idx <= last_idx ? '0 : byte_idx + 1'b1;
          if (last_idx) state <= aes_link_pkg::HEADER;  // Ready for the next frame
        end
        default: state <= aes_link_pkg::HEADER;
      endcase
    end
  end

  // Byte i lands at bits 8i+7:8i
  always_ff @(posedge CLK) begin
    if (rx_valid && state == aes_link_pkg::KEY) key_buf[BW*byte_idx +: BW] <= rx_byte;
    if (rx_valid && state == aes_link_pkg::DATA) data_buf[BW*byte_idx +: BW] <= rx_byte;
  end

  // Both blocks switch together on the last byte
  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      kin <= '0;
      din <= '0;
    end else if (frame_done) begin
      kin <= key_buf;
      din <= {rx_byte, data_buf[aes_link_pkg::BLOCK_BITS-BW-1:0]};
    end
  end

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      ctrl.en    <= 1'b0;
      ctrl.rst_n <= 1'b1;
      ctrl.kdrdy <= 1'b0;
    end else begin
      ctrl.rst_n <= !(rx_valid && state == aes_link_pkg::HEADER && hdr.core_reset);
      ctrl.kdrdy <= frame_done;
      ctrl.en    <= ctrl.en | frame_done;  // Sticky until NRST
    end
  end

  a_byte_idx_range: assert property (@(posedge CLK) disable iff (!NRST)
    byte_idx < aes_link_pkg::byte_idx_t'(aes_link_pkg::BLOCK_BYTES));

endmodule

/* sources.f */
uart_pkg.sv
aes_link_pkg.sv
uart_rx.sv
frame_assembler.sv
block_serializer.sv
uart_tx.sv
aes_uart_bridge.sv
tb_checker.sv
tb_aes_uart_bridge.sv

/* tb_aes_uart_bridge.sv */
// Testbench top with clock, reset, frame table, serial driver and AES core stand-in
module tb_aes_uart_bridge;

  localparam int CLKS_PER_BIT = 8;
  localparam int NUM_TESTS    = 4;
  localparam int WAIT_LIMIT   = 2 * 33 * 10 * CLKS_PER_BIT;  // Two full frames

  logic                    CLK;
  logic                    NRST;
  logic                    rx_uart;
  aes_link_pkg::block_t    dout_aes;
  logic                    dvld_aes;
  logic                    tx_uart;
  aes_link_pkg::block_t    kin_aes;
  aes_link_pkg::block_t    din_aes;
  aes_link_pkg::aes_ctrl_t ctrl_aes;

  // Entry hand-off to the checker
  logic                    exp_push;
  logic [127:0]            exp_name;
  aes_link_pkg::block_t    exp_key;
  aes_link_pkg::block_t    exp_pt;
  logic                    exp_core_reset;
  logic                    chk_done;
  int                      err_cnt;

  // Frame table
  logic [127:0]            t_name  [NUM_TESTS];
  uart_pkg::byte_t         t_hdr   [NUM_TESTS];
  aes_link_pkg::block_t    t_key   [NUM_TESTS];
  aes_link_pkg::block_t    t_pt    [NUM_TESTS];
  int                      t_delay [NUM_TESTS];  // Stand-in cycles before dvld
  int                      seed;

  aes_uart_bridge #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut (
    .CLK      (CLK),
    .NRST     (NRST),
    .rx_uart  (rx_uart),
    .dout_aes (dout_aes),
    .dvld_aes (dvld_aes),
    .tx_uart  (tx_uart),
    .kin_aes  (kin_aes),
    .din_aes  (din_aes),
    .ctrl_aes (ctrl_aes)
  );

  tb_checker #(.CLKS_PER_BIT(CLKS_PER_BIT), .NUM_TESTS(NUM_TESTS)) chk (
    .CLK            (CLK),
    .NRST           (NRST),
    .tx_uart        (tx_uart),
    .kin_aes        (kin_aes),
    .din_aes        (din_aes),
    .ctrl_aes       (ctrl_aes),
    .exp_push       (exp_push),
    .exp_name       (exp_name),
    .exp_key        (exp_key),
    .exp_pt         (exp_pt),
    .exp_core_reset (exp_core_reset),
    .done           (chk_done),
    .err_cnt        (err_cnt)
  );

  always #20 CLK = ~CLK;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $finish;
  endtask

  // One bit period on the serial input
  task automatic hold_line(input logic level);
    rx_uart = level;
    repeat (CLKS_PER_BIT) @(negedge CLK);
  endtask

  task automatic send_byte(input uart_pkg::byte_t data);
    hold_line(1'b0);
    for (int i = 0; i < uart_pkg::BITS_PER_BYTE; i++) hold_line(data[i]);
    hold_line(1'b1);
  endtask

  task automatic fill_table();
    t_name[0]  = "reset_short";
    t_hdr[0]   = 8'h01;
    t_delay[0] = 3;
    t_name[1]  = "plain_long";
    t_hdr[1]   = 8'h00;
    t_delay[1] = 900;
    t_name[2]  = "reset_long";
    t_hdr[2]   = 8'ha5;  // Reserved bits set too
    t_delay[2] = 700;
    t_name[3]  = "plain_short";
    t_hdr[3]   = 8'h7e;
    t_delay[3] = 0;
    for (int n = 0; n < NUM_TESTS; n++) begin
      for (int b = 0; b < aes_link_pkg::BLOCK_BYTES; b++) begin
        t_key[n][8*b +: 8] = 8'($random(seed));
        t_pt[n][8*b +: 8]  = 8'($random(seed));
      end
    end
  endtask

  // AES stand-in answering each kdrdy with kin XOR din
  initial begin
    int                   waited;
    logic                 stalled;
    aes_link_pkg::block_t result;
    dout_aes = '0;
    dvld_aes = 1'b0;
    stalled  = 1'b0;
    for (int n = 0; n < NUM_TESTS && !stalled; n++) begin
      waited = 0;
      do begin
        @(negedge CLK);
        waited++;
      end while (ctrl_aes.kdrdy !== 1'b1 && waited <= WAIT_LIMIT);
      if (ctrl_aes.kdrdy !== 1'b1) begin
        stalled = 1'b1;
        abort_run("Timeout: the DUT gave no key/data-ready pulse");
      end else begin
        result = kin_aes ^ din_aes;
        repeat (t_delay[n]) @(negedge CLK);
        dout_aes = result;
        dvld_aes = 1'b1;
        repeat (4) @(negedge CLK);
        dvld_aes = 1'b0;
        dout_aes = '0;
      end
    end
  end

  initial begin
    int waited;
    CLK            = 1'b0;
    NRST           = 1'b0;
    rx_uart        = 1'b1;
    exp_push       = 1'b0;
    exp_name       = '0;
    exp_key        = '0;
    exp_pt         = '0;
    exp_core_reset = 1'b0;
    seed           = 32'hb0798dc3;
    fill_table();
    repeat (2) @(negedge CLK);
    NRST = 1'b1;
    repeat (4) @(negedge CLK);
    // Results go out while the next frame arrives
    for (int n = 0; n < NUM_TESTS; n++) begin
      exp_name       = t_name[n];
      exp_key        = t_key[n];
      exp_pt         = t_pt[n];
      exp_core_reset = t_hdr[n][0];
      exp_push       = 1'b1;
      @(negedge CLK);
      exp_push = 1'b0;
      send_byte(t_hdr[n]);
      for (int b = 0; b < aes_link_pkg::BLOCK_BYTES; b++) send_byte(t_key[n][8*b +: 8]);
      for (int b = 0; b < aes_link_pkg::BLOCK_BYTES; b++) send_byte(t_pt[n][8*b +: 8]);
    end
    waited = 0;
    while (chk_done !== 1'b1 && waited < WAIT_LIMIT) begin
      @(negedge CLK);
      waited++;
    end
    if (chk_done !== 1'b1) begin
      abort_run("Timeout: the checker did not see all results");
    end else begin
      if (err_cnt == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

/* tb_checker.sv */
// Monitor that checks AES controls and blocks and decodes the serial result bytes
module tb_checker #(
  parameter int CLKS_PER_BIT = 8,
  parameter int NUM_TESTS    = 4
) (
  input  logic                    CLK,
  input  logic                    NRST,
  input  logic                    tx_uart,
  input  aes_link_pkg::block_t    kin_aes,
  input  aes_link_pkg::block_t    din_aes,
  input  aes_link_pkg::aes_ctrl_t ctrl_aes,
  input  logic                    exp_push,
  input  logic [127:0]            exp_name,
  input  aes_link_pkg::block_t    exp_key,
  input  aes_link_pkg::block_t    exp_pt,
  input  logic                    exp_core_reset,
  output logic                    done,
  output int                      err_cnt
);

  localparam int LIMIT = 2 * 33 * 10 * CLKS_PER_BIT;  // Longest gap between result bytes

  logic [127:0]         name_a   [NUM_TESTS];
  aes_link_pkg::block_t key_a    [NUM_TESTS];
  aes_link_pkg::block_t pt_a     [NUM_TESTS];
  logic                 rst_a    [NUM_TESTS];
  int                   ctrl_bad [NUM_TESTS] = '{default: 0};
  int                   push_idx = 0;
  int                   kd_cnt = 0;    // kdrdy pulses seen
  int                   rst_lows = 0;  // rst_n low cycles since the last kdrdy
  logic                 kd_q = 1'b0;
  logic                 rst_checked = 1'b0;
  logic                 en_reported = 1'b0;
  int                   ctrl_err = 0;
  int                   ser_err = 0;

  assign err_cnt = ctrl_err + ser_err;

  always @(posedge CLK) begin
    if (exp_push && push_idx < NUM_TESTS) begin
      name_a[push_idx] = exp_name;
      key_a[push_idx]  = exp_key;
      pt_a[push_idx]   = exp_pt;
      rst_a[push_idx]  = exp_core_reset;
      push_idx = push_idx + 1;
    end
  end

  function automatic int cur_test();
    if (kd_cnt == 0) return 0;
    return (kd_cnt > NUM_TESTS) ? NUM_TESTS - 1 : kd_cnt - 1;
  endfunction

  task automatic check_frame();
    int idx;
    idx = kd_cnt;
    kd_cnt++;
    if (idx >= push_idx) begin
      $display("A kdrdy pulse came with no frame sent");
      ctrl_err++;
    end else begin
      if (kin_aes !== key_a[idx]) begin
        $display("Error %s: kin expected %h, actual %h", name_a[idx], key_a[idx], kin_aes);
        ctrl_bad[idx]++;
      end
      if (din_aes !== pt_a[idx]) begin
        $display("Error %s: din expected %h, actual %h", name_a[idx], pt_a[idx], din_aes);
        ctrl_bad[idx]++;
      end
      if (rst_lows != (rst_a[idx] ? 1 : 0)) begin
        $display("Error %s: rst_n low cycles expected %0d, actual %0d", name_a[idx],
                 rst_a[idx] ? 1 : 0, rst_lows);
        ctrl_bad[idx]++;
      end
      ctrl_err = ctrl_err + ctrl_bad[idx];
    end
    rst_lows = 0;
  endtask

  // Control lines sampled mid-cycle
  always @(negedge CLK) begin
    if (NRST) begin
      if (!rst_checked) begin
        rst_checked = 1'b1;
        if (tx_uart !== 1'b1 || ctrl_aes.en !== 1'b0 || ctrl_aes.rst_n !== 1'b1 ||
            ctrl_aes.kdrdy !== 1'b0) begin
          $display("Error reset: expected tx_uart=1 en=0 rst_n=1 kdrdy=0, actual %b %b %b %b",
                   tx_uart, ctrl_aes.en, ctrl_aes.rst_n, ctrl_aes.kdrdy);
          ctrl_err++;
        end
      end
      if (ctrl_aes.rst_n !== 1'b1) rst_lows++;
      if (ctrl_aes.kdrdy === 1'b1) begin
        if (kd_q) begin
          $display("kdrdy stayed high for more than one cycle");
          ctrl_err++;
        end else begin
          check_frame();
        end
      end
      if (ctrl_aes.en !== (kd_cnt > 0) && !en_reported) begin
        en_reported = 1'b1;  // Once is enough for a stuck enable
        $display("Error %s: en expected %b, actual %b", name_a[cur_test()], kd_cnt > 0,
                 ctrl_aes.en);
        ctrl_err++;
      end
      kd_q = (ctrl_aes.kdrdy === 1'b1);
    end
  end

  task automatic wait_start(output logic found);
    int waited;
    waited = 0;
    found  = 1'b0;
    while (!found && waited < LIMIT) begin
      @(negedge CLK);
      waited++;
      found = (tx_uart === 1'b0);
    end
  endtask

  // Start bit just seen, sample the rest at mid bit
  task automatic read_char(output uart_pkg::byte_t data, output logic framed);
    repeat (CLKS_PER_BIT / 2) @(negedge CLK);
    framed = (tx_uart === 1'b0);
    for (int i = 0; i < uart_pkg::BITS_PER_BYTE; i++) begin
      repeat (CLKS_PER_BIT) @(negedge CLK);
      data[i] = tx_uart;
    end
    repeat (CLKS_PER_BIT) @(negedge CLK);
    framed = framed && (tx_uart === 1'b1);  // Stop bit
  endtask

  initial begin
    uart_pkg::byte_t got;
    uart_pkg::byte_t want;
    logic            found;
    logic            framed;
    logic            lost;
    int              bad;
    int              passed;
    done   = 1'b0;
    lost   = 1'b0;
    passed = 0;
    for (int t = 0; t < NUM_TESTS && !lost; t++) begin
      bad = 0;
      for (int b = 0; b < aes_link_pkg::BLOCK_BYTES && !lost; b++) begin
        wait_start(found);
        if (!found) begin
          $display("Timeout: result byte %0d of test %0d never started on tx_uart", b, t);
          lost = 1'b1;
        end else begin
          read_char(got, framed);
          want = key_a[t][8*b +: 8] ^ pt_a[t][8*b +: 8];
          if (!framed) begin
            $display("Bad start or stop bit on result byte %0d of test %s", b, name_a[t]);
            bad++;
          end
          if (got !== want) begin
            $display("Error %s: result byte %0d expected %h, actual %h", name_a[t], b, want, got);
            bad++;
          end
        end
      end
      if (!lost) begin
        ser_err = ser_err + bad;
        if (bad + ctrl_bad[t] == 0) begin
          $display("Test %s: PASS", name_a[t]);
          passed++;
        end else begin
          $display("Test %s: FAIL", name_a[t]);
        end
      end
    end
    if (lost) begin
      ser_err++;
    end else begin
      // Line must stay idle after the last result
      for (int i = 0; i < 3 * 10 * CLKS_PER_BIT; i++) begin
        @(negedge CLK);
        if (tx_uart !== 1'b1 && !lost) begin
          $display("An extra byte appeared on tx_uart after the last result");
          lost = 1'b1;
          ser_err++;
        end
      end
    end
    if (kd_cnt != NUM_TESTS) begin
      $display("Saw %0d kdrdy pulses for %0d frames", kd_cnt, NUM_TESTS);
      ser_err++;
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS, passed,
             NUM_TESTS - passed, ctrl_err + ser_err);
    @(posedge CLK);
    done = 1'b1;
  end

endmodule

/* uart_pkg.sv */
// UART character width, bit index and byte types with receive and transmit FSM states
package uart_pkg;

  // Data bits per serial character
  localparam int BITS_PER_BYTE = 8;

  // One serial data byte
  typedef logic [BITS_PER_BYTE-1:0] byte_t;

  // Position of a data bit inside a character
  typedef logic [$clog2(BITS_PER_BYTE)-1:0] bit_idx_t;

  // Receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,   // Line high, waiting for a falling edge
    RX_START,  // Run to the middle of the start bit
    RX_DATA,   // Sample data bits, LSB first
    RX_STOP    // Check the stop bit
  } rx_state_e;

  // Transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE,   // Line high, ready for a new byte
    TX_START,  // Start bit low
    TX_DATA,   // Data bits, LSB first
    TX_STOP    // Stop bit high
  } tx_state_e;

endpackage

/* uart_rx.sv */
// Serial receiver with input synchronizer, mid-bit sampling and stop-bit check
module uart_rx #(
  parameter int CLKS_PER_BIT = 10416
) (
  input  logic            CLK,
  input  logic            NRST,
  input  logic            rxd,
  output uart_pkg::byte_t rx_byte,
  output logic            rx_valid
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam uart_pkg::bit_idx_t LAST_BIT =
    uart_pkg::bit_idx_t'(uart_pkg::BITS_PER_BYTE - 1);

  uart_pkg::rx_state_e state;
  logic                rxd_s1;
  logic                rxd_s2;   // Synchronized line
  logic [CNT_W-1:0]    clk_cnt;  // Cycles within the bit
  uart_pkg::bit_idx_t  bit_idx;
  logic                sample;

  // Mid-bit strobe for data bits
  assign sample = (state == uart_pkg::RX_DATA) && (clk_cnt == BIT_END);

  // Two-flop synchronizer, idles high
  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      rxd_s1 <= 1'b1;
      rxd_s2 <= 1'b1;
    end else begin
      rxd_s1 <= rxd;
      rxd_s2 <= rxd_s1;
    end
  end

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      state    <= uart_pkg::RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      clk_cnt  <= clk_cnt + 1'b1;
      case (state)
        uart_pkg::RX_IDLE: begin
          clk_cnt <= '0;
          if (!rxd_s2) state <= uart_pkg::RX_START;
        end
        uart_pkg::RX_START: begin
          if (clk_cnt == HALF_END) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // Line went high again, treat as noise
            state   <= rxd_s2 ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          if (sample) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == LAST_BIT) state <= uart_pkg::RX_STOP;
          end
        end
        uart_pkg::RX_STOP: begin
          if (clk_cnt == BIT_END) begin
            rx_valid <= rxd_s2;  // Framing error drops the byte
            state    <= uart_pkg::RX_IDLE;
          end
        end
        default: state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // Shift in LSB first
  always_ff @(posedge CLK) begin
    if (sample) rx_byte <= {rxd_s2, rx_byte[uart_pkg::BITS_PER_BYTE-1:1]};
  end

  a_rx_valid_single: assert property (@(posedge CLK) disable iff (!NRST)
    rx_valid |=> !rx_valid);

endmodule

/* uart_tx.sv */
// Serial transmitter sending start, eight data bits LSB first and stop
module uart_tx #(
  parameter int CLKS_PER_BIT = 10416
) (
  input  logic            CLK,
  input  logic            NRST,
  input  uart_pkg::byte_t tx_byte,
  input  logic            tx_valid,
  output logic            tx_ready,
  output logic            txd
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);
  localparam uart_pkg::bit_idx_t LAST_BIT =
    uart_pkg::bit_idx_t'(uart_pkg::BITS_PER_BYTE - 1);

  uart_pkg::tx_state_e state;
  logic [CNT_W-1:0]    clk_cnt;
  logic                bit_end;
  uart_pkg::bit_idx_t  bit_idx;
  uart_pkg::byte_t     shift;  // Bit 0 is on the line during DATA

  assign tx_ready = (state == uart_pkg::TX_IDLE);
  assign bit_end  = (clk_cnt == BIT_END);

  always_ff @(posedge CLK or negedge NRST) begin
    if (!NRST) begin
      state   <= uart_pkg::TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (state)
        uart_pkg::TX_IDLE: begin
          clk_cnt <= '0;
          if (tx_valid) begin
            txd   <= 1'b0;  // Start bit
            state <= uart_pkg::TX_START;
          end
        end
        uart_pkg::TX_START: begin
          if (bit_end) begin
            txd     <= shift[0];
            bit_idx <= '0;
            state   <= uart_pkg::TX_DATA;
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            txd     <= (bit_idx == LAST_BIT) ? 1'b1 : shift[1];
            if (bit_idx == LAST_BIT) state <= uart_pkg::TX_STOP;
          end
        end
        uart_pkg::TX_STOP: begin
          if (bit_end) state <= uart_pkg::TX_IDLE;
        end
        default: state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  // Load on hand-off, shift right after each data bit
  always_ff @(posedge CLK) begin
    if (tx_ready && tx_valid) shift <= tx_byte;
    else if (state == uart_pkg::TX_DATA && bit_end) shift <= shift >> 1;
  end

endmodule
